/* compile.f */
design/isa_pkg.sv
design/core_pkg.sv
design/core_control.sv
design/pc_counter.sv
design/decode.sv
design/register_file.sv
design/execute.sv
design/memory.sv
design/core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

/* Makefile */
TOP := core_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verification/core_tb.sv */
`timescale 1ns/10ps

module core_tb;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int IADDR_W    = $clog2(IMEM_WORDS);
  localparam int HALT_LIMIT = 3000;   // Cycles until halt, stalls included
  localparam int READY_LIMIT = 20;

  logic               clk_100mhz;
  logic               sys_rst = 1'b1;
  logic               prog_valid = 1'b0;
  logic [IADDR_W-1:0] prog_addr = '0;
  logic [31:0]        prog_data = 32'd0;
  logic               prog_ready;
  logic               run = 1'b0;
  logic               commit_valid;
  core_pkg::commit_t  commit;
  logic               commit_ready = 1'b1;
  logic               halted;

  logic [31:0]       prog_mem [0:63];   // Program being built
  int                prog_len;
  logic [31:0]       model_regs [0:31];   // Reference state, kept across tests like the DUT
  logic [31:0]       model_dmem [0:DMEM_WORDS-1];
  core_pkg::commit_t expected [0:63];
  core_pkg::commit_t expected_rec;
  int                exp_len;
  int                commit_count;
  int                stall_count;   // Cycles a pending commit was held back
  int                errors;
  int                tests_run;
  int                passed;
  bit                hung;
  bit                stall_en;
  int                seed = 32'h8963_9862;
  string             test_name = "none";

  tb_clock tb_clock_inst (.clk_100mhz(clk_100mhz));

  core_top #(
    .IMEM_WORDS(IMEM_WORDS),
    .DMEM_WORDS(DMEM_WORDS)
  ) core_top_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .prog_valid(prog_valid),
    .prog_addr(prog_addr), .prog_data(prog_data), .prog_ready(prog_ready), .run(run),
    .commit_valid(commit_valid), .commit(commit), .commit_ready(commit_ready),
    .halted(halted)
  );

  always @(posedge clk_100mhz) begin
    if (stall_en) commit_ready <= ($random(seed) & 3) != 0;   // Low about one cycle in four
    else          commit_ready <= 1'b1;
  end

  always @(posedge clk_100mhz) begin
    if (sys_rst)                           commit_count <= 0;
    else if (commit_valid && commit_ready) commit_count <= commit_count + 1;
  end

  always @(posedge clk_100mhz) begin
    if (sys_rst)                            stall_count <= 0;
    else if (commit_valid && !commit_ready) stall_count <= stall_count + 1;
  end

  assign expected_rec = (commit_count < exp_len) ? expected[commit_count[5:0]] : '0;

  commit_matches: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (commit_valid && commit_ready) |-> (commit == expected_rec))
    else begin
      errors++;
      $display("Fail %s: expected %h, actual %h", test_name, $sampled(expected_rec),
               $sampled(commit));
    end

  commit_in_range: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (commit_valid && commit_ready) |-> (commit_count < exp_len))
    else begin
      errors++;
      $display("%s: a commit arrived after the last expected one", test_name);
    end

  // Stalled record must not move or vanish
  commit_held: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
    else begin
      errors++;
      $display("%s: commit_valid fell or the record changed before its handshake", test_name);
    end

  quiet_after_halt: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    halted |-> !commit_valid)
    else begin
      errors++;
      $display("%s: commit_valid was raised after the core halted", test_name);
    end

  function automatic logic [31:0] alu_rr(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                         int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], isa_pkg::OP};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], isa_pkg::F3_ADD_SUB, rd[4:0], isa_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] lw(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], isa_pkg::F3_LW, rd[4:0], isa_pkg::LOAD};
  endfunction

  function automatic logic [31:0] sw(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], isa_pkg::F3_SW, imm[4:0], isa_pkg::STORE};
  endfunction

  function automatic logic [31:0] branch(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], isa_pkg::BRANCH};
  endfunction

  function automatic logic [31:0] lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], isa_pkg::LUI};
  endfunction

  function automatic logic [31:0] jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], isa_pkg::JAL};
  endfunction

  task automatic clear_program();
    for (int i = 0; i < 64; i++) prog_mem[i] = 32'd0;
    prog_len = 0;
  endtask

  task automatic emit(logic [31:0] word);
    prog_mem[prog_len[5:0]] = word;
    prog_len++;
  endtask

  // Walk the program with RV32I rules and list every commit it must make
  task automatic predict_commits();
    logic [31:0] pc, w, a, b, val, next_pc, addr;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        legal, has_rd;
    core_pkg::commit_t rec;
    pc = 32'd0;
    exp_len = 0;
    legal = 1'b1;
    model_regs[0] = 32'd0;
    while (legal && exp_len < 64) begin
      w = prog_mem[pc[7:2]];
      rd = w[11:7];
      f3 = w[14:12];
      rs1 = w[19:15];
      rs2 = w[24:20];
      f7 = w[31:25];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      a = model_regs[rs1];
      b = model_regs[rs2];
      val = 32'd0;
      has_rd = 1'b1;
      next_pc = pc + 32'd4;
      case (w[6:0])
        7'b0110011: begin   // Register-register
          case ({f7, f3})
            10'b0000000_000: val = a + b;
            10'b0100000_000: val = a - b;
            10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'b0000000_100: val = a ^ b;
            10'b0000000_110: val = a | b;
            10'b0000000_111: val = a & b;
            default:         legal = 1'b0;
          endcase
        end
        7'b0010011: if (f3 == 3'b000) val = a + imm_i; else legal = 1'b0;   // ADDI only
        7'b0000011: begin
          addr = a + imm_i;
          if (f3 == 3'b010) val = model_dmem[addr[9:2]]; else legal = 1'b0;
        end
        7'b0100011: begin
          addr = a + imm_s;
          has_rd = 1'b0;
          if (f3 == 3'b010) model_dmem[addr[9:2]] = b; else legal = 1'b0;
        end
        7'b1100011: begin
          has_rd = 1'b0;
          if (f3 == 3'b000 && a == b) next_pc = pc + imm_b;
          else if (f3 == 3'b001 && a != b) next_pc = pc + imm_b;
          else if (f3 != 3'b000 && f3 != 3'b001) legal = 1'b0;
        end
        7'b0110111: val = {w[31:12], 12'd0};
        7'b1101111: begin
          val = pc + 32'd4;   // Link
          next_pc = pc + imm_j;
        end
        default: legal = 1'b0;   // Zero word stops here
      endcase
      if (legal) begin
        rec.pc = pc;
        rec.rd = has_rd ? rd : 5'd0;
        rec.value = val;
        rec.we = has_rd && (rd != 5'd0);
        expected[exp_len[5:0]] = rec;
        if (rec.we) model_regs[rd] = val;
        exp_len++;
        pc = next_pc;
      end
    end
  endtask

  task automatic wait_prog_ready(output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk_100mhz);
    while (!prog_ready && cycles < READY_LIMIT) begin
      @(negedge clk_100mhz);
      cycles++;
    end
    ok = prog_ready;
    if (!ok) $display("%s: load port never became ready", test_name);
  endtask

  task automatic load_program(output bit ok);
    ok = 1'b1;
    for (int i = 0; i < prog_len && ok; i++) begin
      prog_valid <= 1'b1;
      prog_addr <= IADDR_W'(i);
      prog_data <= prog_mem[i];
      wait_prog_ready(ok);
      @(posedge clk_100mhz);   // Transfer edge
    end
    prog_valid <= 1'b0;
  endtask

  task automatic wait_halted(output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk_100mhz);
    while (!halted && cycles < HALT_LIMIT) begin
      @(negedge clk_100mhz);
      cycles++;
    end
    ok = halted;
    if (!ok) $display("%s: core did not halt within %0d cycles", test_name, HALT_LIMIT);
  endtask

  task automatic run_program(input string name, input bit stalls);
    int errors_before;
    bit ok;
    errors_before = errors;
    test_name = name;
    predict_commits();
    @(posedge clk_100mhz);
    stall_en <= stalls;
    sys_rst <= 1'b1;
    run <= 1'b0;
    repeat (8) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    load_program(ok);
    if (ok) begin
      run <= 1'b1;
      wait_halted(ok);
    end
    if (ok) begin
      repeat (20) @(negedge clk_100mhz);   // Window where no commit may appear
      commit_total: assert (commit_count == exp_len)
        else begin
          errors++;
          $display("Fail %s: expected %0d commits, actual %0d", name, exp_len, commit_count);
        end
      stalls_seen: assert (!stalls || stall_count > 0)
        else begin
          errors++;
          $display("%s: commit_ready never held back a pending commit", name);
        end
    end
    hung = hung || !ok;
    tests_run++;
    if (ok && errors == errors_before) passed++;
    $display("%s: %s, %0d of %0d commits", name,
             (ok && errors == errors_before) ? "passed" : "failed", commit_count, exp_len);
  endtask

  task automatic alu_program();
    clear_program();
    emit(addi(1, 0, 25));
    emit(addi(2, 0, -7));
    emit(alu_rr(7'd0, isa_pkg::F3_ADD_SUB, 3, 1, 2));
    emit(alu_rr(isa_pkg::FUNCT7_SUB, isa_pkg::F3_ADD_SUB, 4, 2, 1));   // Negative result
    emit(alu_rr(7'd0, isa_pkg::F3_AND, 5, 1, 2));
    emit(alu_rr(7'd0, isa_pkg::F3_OR, 6, 1, 2));
    emit(alu_rr(7'd0, isa_pkg::F3_XOR, 7, 1, 2));
    emit(alu_rr(7'd0, isa_pkg::F3_SLT, 8, 2, 1));
    emit(alu_rr(7'd0, isa_pkg::F3_SLT, 9, 1, 2));
    emit(addi(10, 2, -100));
    emit(32'd0);
  endtask

  task automatic memory_program();
    clear_program();
    emit(addi(1, 0, 64));   // Base address
    emit(addi(2, 0, 1234));
    emit(addi(3, 0, -5));
    emit(sw(2, 1, 0));
    emit(sw(3, 1, 8));
    emit(lw(4, 1, 0));
    emit(lw(5, 1, 8));
    emit(sw(4, 1, -4));   // Negative offset
    emit(lw(6, 1, -4));
    emit(32'd0);
  endtask

  task automatic branch_program();
    clear_program();
    emit(addi(1, 0, 3));   // Loop counter
    emit(addi(2, 0, 0));
    emit(addi(2, 2, 5));   // Loop body at 8
    emit(addi(1, 1, -1));
    emit(branch(isa_pkg::F3_BNE, 1, 0, -8));
    emit(branch(isa_pkg::F3_BEQ, 1, 0, 8));   // Taken, skips next
    emit(addi(3, 0, 99));
    emit(branch(isa_pkg::F3_BEQ, 2, 0, 8));   // Not taken
    emit(branch(isa_pkg::F3_BNE, 2, 2, 8));
    emit(jal(5, 8));
    emit(addi(3, 0, 77));
    emit(addi(6, 5, 0));   // Copy of the link
    emit(32'd0);
  endtask

  task automatic immediate_program();
    clear_program();
    emit(lui(1, 20'h12345));
    emit(lui(2, 20'hfffff));
    emit(addi(0, 0, 55));   // Dropped write
    emit(alu_rr(7'd0, isa_pkg::F3_ADD_SUB, 3, 0, 0));
    emit(addi(4, 1, 12'h678));
    emit(alu_rr(7'd0, isa_pkg::F3_OR, 5, 0, 2));
    emit(32'd0);
  endtask

  task automatic halt_program();
    clear_program();
    emit(addi(1, 0, 1));
    emit(addi(2, 1, 1));
    emit(32'd0);
    emit(addi(3, 0, 9));   // Past the halt, never retires
  endtask

  initial begin
    errors = 0;
    tests_run = 0;
    passed = 0;
    hung = 1'b0;
    stall_en = 1'b0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    alu_program();
    run_program("alu", 1'b0);
    if (!hung) begin
      memory_program();
      run_program("load_store", 1'b0);
    end
    if (!hung) begin
      branch_program();
      run_program("control_flow", 1'b0);
    end
    if (!hung) begin
      immediate_program();
      run_program("immediates_x0", 1'b0);
    end
    if (!hung) begin
      alu_program();
      run_program("back_pressure", 1'b1);
    end
    if (!hung) begin
      halt_program();
      run_program("halt", 1'b0);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, passed,
             tests_run - passed, errors);
    if (!hung && errors == 0 && passed == tests_run) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 5   // 10 ns period
) (
  output logic clk_100mhz
);

  initial clk_100mhz = 1'b0;

  always #(HALF_PERIOD_NS) clk_100mhz = ~clk_100mhz;

endmodule

/* design/core_top.sv */
`timescale 1ns/10ps

module core_top #(
  parameter  int IMEM_WORDS = 256,
  parameter  int DMEM_WORDS = 256,
  localparam int IADDR_W    = $clog2(IMEM_WORDS)
) (
  input  logic              clk_100mhz,
  input  logic              sys_rst,
  input  logic              prog_valid,
  input  logic [IADDR_W-1:0] prog_addr,
  input  logic [31:0]       prog_data,
  output logic              prog_ready,
  input  logic              run,
  output logic              commit_valid,
  output core_pkg::commit_t commit,
  input  logic              commit_ready,
  output logic              halted
);

  logic [31:0]     pc;
  isa_pkg::instr_t instr;    // Registered fetch word
  core_pkg::uop_t  uop;
  core_pkg::exec_t exec;
  logic [31:0]     rval1;
  logic [31:0]     rval2;
  logic [31:0]     drdata;
  logic [31:0]     wb_data;
  logic            prog_we;
  logic            fetch_en;
  logic            dmem_re;
  logic            dmem_we;
  logic            rf_we;
  logic            pc_step;
  logic            pc_load;

  assign prog_we = prog_valid && prog_ready;   // Load handshake
  assign wb_data = (uop.itype == core_pkg::LD) ? drdata : exec.result;

  always_comb begin
    commit.pc    = uop.pc;
    commit.rd    = uop.rd;
    commit.value = wb_data;
    commit.we    = core_pkg::writes_rd(uop.itype) && (uop.rd != 5'd0);   // x0 never counts
  end

  core_control core_control_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .run(run), .itype(uop.itype),
    .commit_ready(commit_ready), .prog_ready(prog_ready), .fetch_en(fetch_en),
    .dmem_re(dmem_re), .dmem_we(dmem_we), .rf_we(rf_we), .pc_step(pc_step),
    .pc_load(pc_load), .commit_valid(commit_valid), .halted(halted)
  );

  pc_counter pc_counter_inst (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .step(pc_step), .load(pc_load),
    .target(exec.next_pc), .pc(pc)
  );

  decode decode_inst (.instr(instr), .pc(pc), .uop(uop));

  register_file register_file_inst (
    .clk_100mhz(clk_100mhz), .rs1(uop.rs1), .rs2(uop.rs2), .rd(uop.rd),
    .wd(wb_data), .we(rf_we), .rd1(rval1), .rd2(rval2)
  );

  execute execute_inst (.uop(uop), .rval1(rval1), .rval2(rval2), .exec(exec));

  memory #(
    .IMEM_WORDS(IMEM_WORDS),
    .DMEM_WORDS(DMEM_WORDS)
  ) memory_inst (
    .clk_100mhz(clk_100mhz), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .fetch_en(fetch_en), .pc(pc), .instr(instr),
    .dmem_re(dmem_re), .dmem_we(dmem_we), .daddr(exec.addr), .dwdata(rval2),
    .drdata(drdata)
  );

endmodule

/* design/memory.sv */
`timescale 1ns/10ps

module memory #(
  parameter  int IMEM_WORDS = 256,
  parameter  int DMEM_WORDS = 256,
  localparam int IADDR_W    = $clog2(IMEM_WORDS),
  localparam int DADDR_W    = $clog2(DMEM_WORDS)
) (
  input  logic               clk_100mhz,
  input  logic               prog_we,
  input  logic [IADDR_W-1:0] prog_addr,   // Word index
  input  logic [31:0]        prog_data,
  input  logic               fetch_en,
  input  logic [31:0]        pc,
  output isa_pkg::instr_t    instr,
  input  logic               dmem_re,
  input  logic               dmem_we,
  input  logic [31:0]        daddr,       // Byte address
  input  logic [31:0]        dwdata,
  output logic [31:0]        drdata
);

  logic [31:0]        imem [IMEM_WORDS];
  logic [31:0]        dmem [DMEM_WORDS];
  logic [IADDR_W-1:0] iaddr;
  logic [DADDR_W-1:0] dword;

  assign iaddr = pc[IADDR_W+1:2];      // Drop byte offset
  assign dword = daddr[DADDR_W+1:2];

  always_ff @(posedge clk_100mhz) begin
    if (prog_we) imem[prog_addr] <= prog_data;   // Load port only while idle
  end

  always_ff @(posedge clk_100mhz) begin
    if (fetch_en) instr <= imem[iaddr];   // Held until the next fetch
  end

  always_ff @(posedge clk_100mhz) begin
    if (dmem_we) dmem[dword] <= dwdata;
    if (dmem_re) drdata <= dmem[dword];   // Stable through writeback
  end

endmodule

/* design/execute.sv */
`timescale 1ns/10ps

module execute (
  input  core_pkg::uop_t  uop,
  input  logic [31:0]     rval1,
  input  logic [31:0]     rval2,
  output core_pkg::exec_t exec
);

  logic [31:0] op_b;      // Second ALU operand
  logic [31:0] alu_out;
  logic        equal;
  logic [31:0] pc_plus4;

  assign op_b     = (uop.itype == core_pkg::ALU_IMM) ? uop.imm : rval2;
  assign equal    = (rval1 == rval2);
  assign pc_plus4 = uop.pc + 32'd4;

  always_comb begin
    case (uop.alu_func)
      core_pkg::ADD: alu_out = rval1 + op_b;
      core_pkg::SUB: alu_out = rval1 - op_b;
      core_pkg::AND: alu_out = rval1 & op_b;
      core_pkg::OR:  alu_out = rval1 | op_b;
      core_pkg::XOR: alu_out = rval1 ^ op_b;
      core_pkg::SLT: alu_out = {31'd0, $signed(rval1) < $signed(op_b)};
      default:       alu_out = 32'd0;
    endcase
  end

  always_comb begin
    exec         = '0;
    exec.next_pc = pc_plus4;   // Fall-through
    case (uop.itype)
      core_pkg::ALU, core_pkg::ALU_IMM: exec.result = alu_out;
      core_pkg::LD, core_pkg::ST:       exec.addr   = rval1 + uop.imm;
      core_pkg::BR: begin
        exec.taken = (uop.br_func == core_pkg::EQ) ? equal : !equal;
        if (exec.taken) exec.next_pc = uop.pc + uop.imm;
      end
      core_pkg::JAL_T: begin
        exec.taken   = 1'b1;
        exec.next_pc = uop.pc + uop.imm;
        exec.result  = pc_plus4;   // Link value
      end
      core_pkg::LUI_T: exec.result = uop.imm;
      default:         exec.result = 32'd0;
    endcase
  end

endmodule

/* design/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic        clk_100mhz,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic [31:0] wd,
  input  logic        we,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [1:31];   // No storage behind x0

  always_ff @(posedge clk_100mhz) begin
    if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  // Combinational reads, x0 forced to zero
  assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* design/decode.sv */
`timescale 1ns/10ps

module decode (
  input  isa_pkg::instr_t instr,
  input  logic [31:0]     pc,
  output core_pkg::uop_t  uop
);

  always_comb begin
    uop          = '0;
    uop.itype    = core_pkg::ILLEGAL;   // Unless a case below matches
    uop.alu_func = core_pkg::ADD;
    uop.br_func  = core_pkg::EQ;
    uop.pc       = pc;
    case (instr.r_fmt.opcode)
      isa_pkg::OP: begin
        uop.rs1 = instr.r_fmt.rs1;
        uop.rs2 = instr.r_fmt.rs2;
        uop.rd  = instr.r_fmt.rd;
        if (instr.r_fmt.funct7 == isa_pkg::FUNCT7_SUB) begin
          if (instr.r_fmt.funct3 == isa_pkg::F3_ADD_SUB) begin
            uop.itype    = core_pkg::ALU;
            uop.alu_func = core_pkg::SUB;
          end
        end else if (instr.r_fmt.funct7 == 7'd0) begin
          uop.itype = core_pkg::ALU;
          case (instr.r_fmt.funct3)
            isa_pkg::F3_ADD_SUB: uop.alu_func = core_pkg::ADD;
            isa_pkg::F3_SLT:     uop.alu_func = core_pkg::SLT;
            isa_pkg::F3_XOR:     uop.alu_func = core_pkg::XOR;
            isa_pkg::F3_OR:      uop.alu_func = core_pkg::OR;
            isa_pkg::F3_AND:     uop.alu_func = core_pkg::AND;
            default:             uop.itype    = core_pkg::ILLEGAL;   // Shifts, SLTU
          endcase
        end
      end
      isa_pkg::OP_IMM, isa_pkg::LOAD: begin
        uop.rs1 = instr.i_fmt.rs1;
        uop.rd  = instr.i_fmt.rd;
        uop.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        if (instr.i_fmt.opcode == isa_pkg::OP_IMM) begin
          if (instr.i_fmt.funct3 == isa_pkg::F3_ADD_SUB) uop.itype = core_pkg::ALU_IMM;  // ADDI
        end else if (instr.i_fmt.funct3 == isa_pkg::F3_LW) begin
          uop.itype = core_pkg::LD;
        end
      end
      isa_pkg::STORE: begin
        uop.rs1 = instr.s_fmt.rs1;
        uop.rs2 = instr.s_fmt.rs2;
        uop.imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
        if (instr.s_fmt.funct3 == isa_pkg::F3_SW) uop.itype = core_pkg::ST;
      end
      isa_pkg::BRANCH: begin
        uop.rs1 = instr.b_fmt.rs1;
        uop.rs2 = instr.b_fmt.rs2;
        uop.imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                   instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};   // Halfword offset
        if (instr.b_fmt.funct3 == isa_pkg::F3_BEQ) begin
          uop.itype   = core_pkg::BR;
          uop.br_func = core_pkg::EQ;
        end else if (instr.b_fmt.funct3 == isa_pkg::F3_BNE) begin
          uop.itype   = core_pkg::BR;
          uop.br_func = core_pkg::NE;
        end
      end
      isa_pkg::LUI: begin
        uop.itype = core_pkg::LUI_T;
        uop.rd    = instr.u_fmt.rd;
        uop.imm   = {instr.u_fmt.imm, 12'd0};
      end
      isa_pkg::JAL: begin
        uop.itype = core_pkg::JAL_T;
        uop.rd    = instr.j_fmt.rd;
        uop.imm   = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                     instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
      end
      default: uop.itype = core_pkg::ILLEGAL;   // All-zero word lands here
    endcase
  end

endmodule

/* design/pc_counter.sv */
`timescale 1ns/10ps

module pc_counter (
  input  logic        clk_100mhz,
  input  logic        sys_rst,
  input  logic        step,
  input  logic        load,
  input  logic [31:0] target,
  output logic [31:0] pc
);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      pc <= 32'd0;   // Boot address
    end else if (load) begin
      pc <= target;   // Branch or jump
    end else if (step) begin
      pc <= pc + 32'd4;
    end
  end

  // Misaligned targets would fetch the wrong word
  pc_aligned: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    pc[1:0] == 2'b00);

endmodule

/* design/core_control.sv */
`timescale 1ns/10ps

module core_control (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic             run,
  input  core_pkg::itype_e itype,
  input  logic             commit_ready,
  output logic             prog_ready,
  output logic             fetch_en,
  output logic             dmem_re,
  output logic             dmem_we,
  output logic             rf_we,
  output logic             pc_step,
  output logic             pc_load,
  output logic             commit_valid,
  output logic             halted
);

  core_pkg::state_e state;
  core_pkg::state_e state_next;
  logic             wb_fire;   // Commit handshake this cycle
  logic             redirect;  // BR or JAL take next_pc

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state <= core_pkg::S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;   // Hold by default
    case (state)
      core_pkg::S_IDLE:    if (run) state_next = core_pkg::S_FETCH;
      core_pkg::S_FETCH:   state_next = core_pkg::S_DECODE;
      core_pkg::S_DECODE: begin
        if (itype == core_pkg::ILLEGAL) begin
          state_next = core_pkg::S_HALT;   // Zero or unsupported word
        end else begin
          state_next = core_pkg::S_EXECUTE;
        end
      end
      core_pkg::S_EXECUTE: begin
        if (itype == core_pkg::LD || itype == core_pkg::ST) begin
          state_next = core_pkg::S_MEMORY;
        end else begin
          state_next = core_pkg::S_WRITEBACK;
        end
      end
      core_pkg::S_MEMORY:    state_next = core_pkg::S_WRITEBACK;
      core_pkg::S_WRITEBACK: if (commit_ready) state_next = core_pkg::S_FETCH;
      core_pkg::S_HALT:      state_next = core_pkg::S_HALT;   // Until reset
      default:               state_next = core_pkg::S_IDLE;
    endcase
  end

  assign wb_fire  = (state == core_pkg::S_WRITEBACK) && commit_ready;
  assign redirect = (itype == core_pkg::BR) || (itype == core_pkg::JAL_T);

  assign prog_ready   = (state == core_pkg::S_IDLE);
  assign fetch_en     = (state == core_pkg::S_FETCH);
  assign dmem_re      = (state == core_pkg::S_MEMORY) && (itype == core_pkg::LD);
  assign dmem_we      = (state == core_pkg::S_MEMORY) && (itype == core_pkg::ST);
  assign rf_we        = wb_fire && core_pkg::writes_rd(itype);
  assign pc_load      = wb_fire && redirect;
  assign pc_step      = wb_fire && !redirect;
  assign commit_valid = (state == core_pkg::S_WRITEBACK);   // Held until accepted
  assign halted       = (state == core_pkg::S_HALT);

  state_legal: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    state inside {core_pkg::S_IDLE, core_pkg::S_FETCH, core_pkg::S_DECODE,
                  core_pkg::S_EXECUTE, core_pkg::S_MEMORY, core_pkg::S_WRITEBACK,
                  core_pkg::S_HALT});

  // Decoded class must not move while a commit waits
  itype_held_in_stall: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (commit_valid && !commit_ready) |=> $stable(itype));

endmodule

/* design/core_pkg.sv */
package core_pkg;

  typedef enum logic [2:0] {
    S_IDLE,        // Waiting for run, load port open
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEMORY,      // LD and ST only
    S_WRITEBACK,   // Commit handshake
    S_HALT
  } state_e;

  typedef enum logic [2:0] {
    ALU, ALU_IMM, LD, ST, BR, LUI_T, JAL_T, ILLEGAL
  } itype_e;

  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLT
  } alu_func_e;

  typedef enum logic {
    EQ, NE
  } br_func_e;

  typedef struct packed {
    itype_e      itype;
    alu_func_e   alu_func;
    br_func_e    br_func;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;   // Already sign-extended
    logic [31:0] pc;
  } uop_t;

  typedef struct packed {
    logic [31:0] result;
    logic [31:0] addr;      // Data byte address
    logic [31:0] next_pc;
    logic        taken;
  } exec_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        we;
  } commit_t;

  // Instruction classes with a destination register
  function automatic logic writes_rd(itype_e itype);
    return itype inside {ALU, ALU_IMM, LD, LUI_T, JAL_T};
  endfunction

endpackage

/* design/isa_pkg.sv */
package isa_pkg;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,   // Register-register ALU
    OP_IMM = 7'b0010011,   // Register-immediate ALU
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111
  } opcode_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;   // Also ADDI
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;   // Word only
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;   // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;   // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;   // imm[31:12]
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, six views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

endpackage
